/* rtl/fetch_cfg.svh */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// boot address, first word fetched once reset drops
`define FETCH_RESET_PC 32'hbfc0_0000

// trap entry until software moves it, word aligned
`define FETCH_EXC_VECTOR_RST 32'hbfc0_0380

// extra memory cycles per fetch out of reset
`define FETCH_WAIT_RST 2'd1

// word address bits of the instruction memory, 256 words
`define IMEM_AW 8

`endif

/* rtl/fetch_pkg.sv */
`default_nettype none

`include "fetch_cfg.svh"

package fetch_pkg;

    // bit of the exception code flagging a misaligned fetch
    localparam int EXC_ADEL_BIT = 6;

    // taken branch from decode
    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } br_bus_t;

    // trap entry or return
    typedef struct packed {
        logic        is_exc;
        logic        is_eret;
        logic [31:0] epc;
    } exc_eret_bus_t;

    // instruction handed to decode
    typedef struct packed {
        logic        exc;
        logic [7:0]  exc_code;
        logic [31:0] inst;
        logic [31:0] pc;
    } fs_to_ds_bus_t;

    typedef struct packed {
        logic [31:0] exc_vector;
        logic [1:0]  wait_states;
    } fetch_cfg_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } imem_req_t;

    // program load, word addressed
    typedef struct packed {
        logic                we;
        logic [`IMEM_AW-1:0] addr;
        logic [31:0]         data;
    } imem_load_t;

endpackage

`default_nettype wire

/* rtl/fetch_csr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_csr (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cfg_we,
    input  logic                   cfg_sel,
    input  logic [31:0]            cfg_wdata,
    output fetch_pkg::fetch_cfg_t  cfg
);

    logic [31:0] exc_vector_q;
    logic [1:0]  wait_q;

    // sel 0 writes the vector, sel 1 the wait count
    always_ff @(posedge clk) begin
        if (reset) begin
            exc_vector_q <= `FETCH_EXC_VECTOR_RST;
            wait_q       <= `FETCH_WAIT_RST;
        end else if (cfg_we) begin
            if (cfg_sel) begin
                wait_q <= cfg_wdata[1:0];
            end else begin
                // trap target always word aligned
                exc_vector_q <= {cfg_wdata[31:2], 2'b00};
            end
        end
    end

    assign cfg.exc_vector  = exc_vector_q;
    assign cfg.wait_states = wait_q;

endmodule

`default_nettype wire

/* rtl/if_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module if_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      ds_allowin,
    input  fetch_pkg::br_bus_t        br_bus,
    input  fetch_pkg::exc_eret_bus_t  exc_eret_bus,
    input  logic [31:0]               exc_vector,
    output logic                      fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_bus_t  fs_to_ds_bus,
    output fetch_pkg::imem_req_t      imem_req,
    input  logic                      imem_data_ok,
    input  logic [31:0]               imem_rdata
);

    import fetch_pkg::*;

    logic        to_fs_valid;
    logic        fs_valid;
    logic [31:0] fs_pc;
    logic        fs_ready_go;
    logic        fs_allowin;
    logic        transfer;
    logic        accept_pc;

    logic [31:0] seq_pc;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic [31:0] next_pc;

    logic        inst_buf_valid;
    logic [31:0] inst_buf;

    logic        fs_adel;
    logic [7:0]  exc_code;

    // next pc selection
    assign seq_pc   = fs_pc + 32'd4;
    assign redirect = exc_eret_bus.is_exc || exc_eret_bus.is_eret || br_bus.taken;

    always_comb begin
        if (exc_eret_bus.is_exc) begin
            redirect_pc = exc_vector;
        end else if (exc_eret_bus.is_eret) begin
            redirect_pc = exc_eret_bus.epc;
        end else begin
            redirect_pc = br_bus.target;
        end
    end

    // pc holds while decode stalls, so the sequential pc is held with it
    assign next_pc = redirect ? redirect_pc : seq_pc;

    assign to_fs_valid    = !reset;
    // a return in the flush cycle is dropped
    // older returns never come since the flush request replaces them
    assign fs_ready_go    = (imem_data_ok || inst_buf_valid) && !flush;
    assign fs_to_ds_valid = fs_valid && fs_ready_go;
    assign transfer       = fs_to_ds_valid && ds_allowin;
    assign fs_allowin     = !fs_valid || transfer;

    // flush restarts the fetch whatever is held
    assign accept_pc = to_fs_valid && (fs_allowin || flush);

    assign imem_req.valid = accept_pc;
    assign imem_req.addr  = next_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
            // one word before boot so the first sequential pc is the boot pc
            fs_pc    <= `FETCH_RESET_PC - 32'd4;
        end else if (accept_pc) begin
            fs_valid <= 1'b1;
            fs_pc    <= next_pc;
        end
    end

    // returned word kept until decode takes it
    always_ff @(posedge clk) begin
        if (reset) begin
            inst_buf_valid <= 1'b0;
        end else if (accept_pc) begin
            inst_buf_valid <= 1'b0;
        end else if (imem_data_ok) begin
            inst_buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (imem_data_ok) begin
            inst_buf <= imem_rdata;
        end
    end

    // misaligned fetch raises address error
    assign fs_adel  = fs_pc[1:0] != 2'b00;
    assign exc_code = 8'(fs_adel) << EXC_ADEL_BIT;

    assign fs_to_ds_bus.exc      = |exc_code;
    assign fs_to_ds_bus.exc_code = exc_code;
    assign fs_to_ds_bus.inst     = inst_buf_valid ? inst_buf : imem_rdata;
    assign fs_to_ds_bus.pc       = fs_pc;

endmodule

`default_nettype wire

/* rtl/inst_sram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module inst_sram (
    input  logic                    clk,
    input  logic                    reset,
    input  fetch_pkg::imem_req_t    req,
    input  logic [1:0]              wait_states,
    input  fetch_pkg::imem_load_t   load,
    output logic                    data_ok,
    output logic [31:0]             rdata
);

    localparam int DEPTH = 2 ** `IMEM_AW;

    logic [31:0]         mem [DEPTH];
    logic [`IMEM_AW-1:0] addr_q;
    logic                pending_q;
    logic [1:0]          cnt_q;

    // program load port
    always_ff @(posedge clk) begin
        if (load.we) begin
            mem[load.addr] <= load.data;
        end
    end

    // byte offset dropped, upper bits wrap
    always_ff @(posedge clk) begin
        if (req.valid) begin
            addr_q <= req.addr[`IMEM_AW+1:2];
        end
    end

    // wait count sampled with the request
    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q <= 1'b0;
            cnt_q     <= 2'd0;
        end else if (req.valid) begin
            // a new request replaces a pending one
            pending_q <= 1'b1;
            cnt_q     <= wait_states;
        end else if (data_ok) begin
            pending_q <= 1'b0;
        end else if (pending_q) begin
            cnt_q <= cnt_q - 2'd1;
        end
    end

    assign data_ok = pending_q && (cnt_q == 2'd0);
    assign rdata   = mem[addr_q];

endmodule

`default_nettype wire

/* rtl/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      ds_allowin,
    input  fetch_pkg::br_bus_t        br_bus,
    input  fetch_pkg::exc_eret_bus_t  exc_eret_bus,
    input  logic                      cfg_we,
    input  logic                      cfg_sel,
    input  logic [31:0]               cfg_wdata,
    input  fetch_pkg::imem_load_t     load,
    output logic                      fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_bus_t  fs_to_ds_bus
);

    import fetch_pkg::*;

    fetch_cfg_t   cfg;
    imem_req_t    imem_req;
    logic         imem_data_ok;
    logic [31:0]  imem_rdata;

    fetch_csr csr_i (
        .clk       (clk),
        .reset     (reset),
        .cfg_we    (cfg_we),
        .cfg_sel   (cfg_sel),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg)
    );

    if_stage if_i (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .ds_allowin     (ds_allowin),
        .br_bus         (br_bus),
        .exc_eret_bus   (exc_eret_bus),
        .exc_vector     (cfg.exc_vector),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .imem_req       (imem_req),
        .imem_data_ok   (imem_data_ok),
        .imem_rdata     (imem_rdata)
    );

    // wait states come from the config block
    inst_sram imem_i (
        .clk         (clk),
        .reset       (reset),
        .req         (imem_req),
        .wait_states (cfg.wait_states),
        .load        (load),
        .data_ok     (imem_data_ok),
        .rdata       (imem_rdata)
    );

endmodule

`default_nettype wire

/* test/fetch_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_asserts (
    input logic                     clk,
    input logic                     reset,
    input logic                     flush,
    input logic                     ds_allowin,
    input fetch_pkg::br_bus_t       br_bus,
    input fetch_pkg::exc_eret_bus_t exc_eret_bus,
    input logic                     cfg_we,
    input logic                     cfg_sel,
    input logic [31:0]              cfg_wdata,
    input fetch_pkg::imem_load_t    load,
    input logic                     fs_to_ds_valid,
    input fetch_pkg::fs_to_ds_bus_t fs_to_ds_bus
);

    import fetch_pkg::*;

    logic [31:0]   shadow [2 ** `IMEM_AW];
    logic [31:0]   exp_pc;
    logic [31:0]   vector_m;
    logic [1:0]    wait_m;
    logic [2:0]    since_slow_flush;
    logic          first_q;
    logic          hold_q;
    fs_to_ds_bus_t held_bus;
    logic          transfer;
    logic          misaligned;
    logic [31:0]   shadow_word;

    bit   fail_reset;
    bit   fail_first;
    bit   fail_inst;
    bit   fail_pc;
    bit   fail_adel;
    bit   fail_hold;
    bit   fail_wait;
    logic fail_any;

    assign transfer    = fs_to_ds_valid && ds_allowin;
    assign misaligned  = fs_to_ds_bus.pc[1:0] != 2'b00;
    assign shadow_word = shadow[fs_to_ds_bus.pc[`IMEM_AW+1:2]];
    assign fail_any    = fail_reset | fail_first | fail_inst | fail_pc |
                         fail_adel | fail_hold | fail_wait;

    // copy of the program as it goes through the load port
    always_ff @(posedge clk) begin
        if (load.we) begin
            shadow[load.addr] <= load.data;
        end
    end

    // config mirror, a write shows one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            vector_m <= `FETCH_EXC_VECTOR_RST;
            wait_m   <= `FETCH_WAIT_RST;
        end else if (cfg_we && cfg_sel) begin
            wait_m <= cfg_wdata[1:0];
        end else if (cfg_we) begin
            vector_m <= {cfg_wdata[31:2], 2'b00};
        end
    end

    // pc the next delivered word must carry
    always_ff @(posedge clk) begin
        if (reset) begin
            exp_pc <= `FETCH_RESET_PC;
        end else if (flush || transfer) begin
            if (exc_eret_bus.is_exc) begin
                exp_pc <= vector_m;
            end else if (exc_eret_bus.is_eret) begin
                exp_pc <= exc_eret_bus.epc;
            end else if (br_bus.taken) begin
                exp_pc <= br_bus.target;
            end else begin
                exp_pc <= exp_pc + 32'd4;
            end
        end
    end

    // counts the three quiet cycles after a flush with wait count 3
    always_ff @(posedge clk) begin
        held_bus <= fs_to_ds_bus;
        if (reset) begin
            first_q          <= 1'b1;
            hold_q           <= 1'b0;
            since_slow_flush <= 3'd0;
        end else begin
            hold_q <= fs_to_ds_valid && !ds_allowin;
            if (transfer || flush) begin
                first_q <= 1'b0;
            end
            if (flush) begin
                since_slow_flush <= (wait_m == 2'd3) ? 3'd1 : 3'd0;
            end else if (since_slow_flush != 3'd0 && since_slow_flush < 3'd3) begin
                since_slow_flush <= since_slow_flush + 3'd1;
            end else begin
                since_slow_flush <= 3'd0;
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk) reset |-> !fs_to_ds_valid)
        else begin
            fail_reset = 1'b1;
            $error("ERR %0t fs_to_ds_valid got %b expected 0", $time,
                   $sampled(fs_to_ds_valid));
        end

    a_first_pc: assert property (@(posedge clk) disable iff (reset)
        (transfer && first_q) |-> fs_to_ds_bus.pc == `FETCH_RESET_PC)
        else begin
            fail_first = 1'b1;
            $error("ERR %0t fs_to_ds_bus.pc got %h expected %h", $time,
                   $sampled(fs_to_ds_bus.pc), `FETCH_RESET_PC);
        end

    a_inst: assert property (@(posedge clk) disable iff (reset)
        fs_to_ds_valid |-> fs_to_ds_bus.inst == shadow_word)
        else begin
            fail_inst = 1'b1;
            $error("ERR %0t fs_to_ds_bus.inst got %h expected %h", $time,
                   $sampled(fs_to_ds_bus.inst), $sampled(shadow_word));
        end

    a_pc: assert property (@(posedge clk) disable iff (reset)
        fs_to_ds_valid |-> fs_to_ds_bus.pc == exp_pc)
        else begin
            fail_pc = 1'b1;
            $error("ERR %0t fs_to_ds_bus.pc got %h expected %h", $time,
                   $sampled(fs_to_ds_bus.pc), $sampled(exp_pc));
        end

    // misaligned pc raises the address error and nothing else
    a_adel: assert property (@(posedge clk) disable iff (reset)
        fs_to_ds_valid |-> (fs_to_ds_bus.exc == misaligned &&
                            fs_to_ds_bus.exc_code[EXC_ADEL_BIT] == misaligned &&
                            (fs_to_ds_bus.exc_code & ~(8'd1 << EXC_ADEL_BIT)) == 8'd0))
        else begin
            fail_adel = 1'b1;
            $error("ERR %0t fs_to_ds_bus.exc_code got %h expected adel %b", $time,
                   $sampled(fs_to_ds_bus.exc_code), $sampled(misaligned));
        end

    a_hold: assert property (@(posedge clk) disable iff (reset)
        (hold_q && !flush) |-> (fs_to_ds_valid && fs_to_ds_bus == held_bus))
        else begin
            fail_hold = 1'b1;
            $error("ERR %0t fs_to_ds_bus got %h expected %h (valid %b)", $time,
                   $sampled(fs_to_ds_bus), $sampled(held_bus), $sampled(fs_to_ds_valid));
        end

    a_wait: assert property (@(posedge clk) disable iff (reset)
        since_slow_flush != 3'd0 |-> !fs_to_ds_valid)
        else begin
            fail_wait = 1'b1;
            $error("ERR %0t fs_to_ds_valid got %b expected 0, cycle %0d after flush", $time,
                   $sampled(fs_to_ds_valid), $sampled(since_slow_flush));
        end

endmodule

`default_nettype wire

/* test/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_tb;

    import fetch_pkg::*;

    localparam int DEPTH        = 2 ** `IMEM_AW;
    localparam int RESET_CYCLES = 8;
    localparam int RUN_CYCLES   = 1244;
    // program load plus random phase, twice over
    localparam int MAX_CYCLES   = 2 * (DEPTH + RUN_CYCLES);

    logic          clk;
    logic          reset;
    logic          flush;
    logic          ds_allowin;
    br_bus_t       br_bus;
    exc_eret_bus_t exc_eret_bus;
    logic          cfg_we;
    logic          cfg_sel;
    logic [31:0]   cfg_wdata;
    imem_load_t    load;
    logic          fs_to_ds_valid;
    fs_to_ds_bus_t fs_to_ds_bus;

    integer seed;
    int     cycle_count;

    fetch_top dut_i (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .ds_allowin     (ds_allowin),
        .br_bus         (br_bus),
        .exc_eret_bus   (exc_eret_bus),
        .cfg_we         (cfg_we),
        .cfg_sel        (cfg_sel),
        .cfg_wdata      (cfg_wdata),
        .load           (load),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus)
    );

    bind fetch_top fetch_asserts asserts_i (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .ds_allowin     (ds_allowin),
        .br_bus         (br_bus),
        .exc_eret_bus   (exc_eret_bus),
        .cfg_we         (cfg_we),
        .cfg_sel        (cfg_sel),
        .cfg_wdata      (cfg_wdata),
        .load           (load),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the stimulus did not finish within %0d cycles", MAX_CYCLES);
        $display("Test FAILED");
        $fatal(1, "timeout");
    end

    // a bound assertion has fired
    initial begin
        wait (dut_i.asserts_i.fail_any);
        $display("Test FAILED");
        $fatal(1, "assertion failure in fetch_top");
    end

    task automatic drive_idle();
        flush        = 1'b0;
        ds_allowin   = 1'b0;
        br_bus       = '0;
        exc_eret_bus = '0;
        cfg_we       = 1'b0;
        cfg_sel      = 1'b0;
        cfg_wdata    = '0;
        load         = '0;
    endtask

    // reset drops partway, decode stays stalled until the last word is in
    task automatic load_program();
        for (int i = 0; i < DEPTH; i++) begin
            if (i == RESET_CYCLES) begin
                reset = 1'b0;
            end
            load.we   = 1'b1;
            load.addr = `IMEM_AW'(i);
            load.data = $random(seed);
            @(negedge clk);
        end
        load = '0;
    endtask

    task automatic drive_random_cycle();
        logic        can_redirect;
        logic [31:0] r;
        logic [31:0] addr;
        // valid seen before the new inputs, so a transfer is certain
        can_redirect = fs_to_ds_valid;
        r            = $random(seed);
        addr         = $random(seed);
        flush        = (r[4:0] == 5'd0);
        ds_allowin   = r[5] | r[6];
        cfg_we       = (r[11:8] == 4'd0);
        cfg_sel      = r[12];
        cfg_wdata    = $random(seed);
        br_bus       = '0;
        exc_eret_bus = '0;
        if (flush) begin
            exc_eret_bus.is_exc  = r[13];
            exc_eret_bus.is_eret = !r[13];
            exc_eret_bus.epc     = {addr[31:2], 2'b00};
        end else if (can_redirect && ds_allowin && r[15:14] == 2'b00) begin
            br_bus.taken  = 1'b1;
            // now and then a misaligned target
            br_bus.target = (r[19:16] == 4'd0) ? addr : {addr[31:2], 2'b00};
        end
    endtask

    initial begin
        seed  = 32'h2b5c8f43;
        reset = 1'b1;
        drive_idle();
        load_program();
        for (int i = 0; i < RUN_CYCLES; i++) begin
            drive_random_cycle();
            @(negedge clk);
        end
        drive_idle();
        repeat (8) @(negedge clk);
        if (dut_i.asserts_i.fail_any) begin
            $display("Test FAILED");
            $fatal(1, "assertion failure in fetch_top");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_csr.sv
rtl/if_stage.sv
rtl/inst_sram.sv
rtl/fetch_top.sv
test/fetch_asserts.sv
test/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module fetch_tb \
    -o fetch_sim

out="$(./obj_dir/fetch_sim +verilator+error+limit+1000 2>&1 || true)"
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
